// ==== Makefile ====
# Verilator build and run for the debug subsystem control block

VERILATOR ?= verilator
TOP       ?= tb_osd_scm
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= RESULT: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/scm_stim.txt ====
# S n w..: send n flits, last on the final one. E n w..: expect n response flits
# C sys cpu: check reset lines. B 1 or 0: random output back-pressure on or off
C 0 0
S 4 0005 0010 0000 0000
E 4 0010 0005 2000 0001
S 4 0005 0010 0000 0001
E 4 0010 0005 2000 0001
S 4 0005 0010 0000 0002
E 4 0010 0005 2000 0000
S 4 0005 0010 0000 0200
E 4 0010 0005 2000 0001
S 4 0005 0010 0000 0201
E 4 0010 0005 2000 0002
S 4 0005 0010 0000 0202
E 4 0010 0005 2000 0001
S 4 0005 0010 0000 0203
E 4 0010 0005 2000 000c
# Reset vector writes and read back
S 5 0005 0010 1000 0204 0001
E 3 0010 0005 3800
C 1 0
S 4 0005 0010 0000 0204
E 4 0010 0005 2000 0001
S 5 0005 0010 1000 0204 0002
E 3 0010 0005 3800
C 0 1
S 4 0005 0010 0000 0204
E 4 0010 0005 2000 0002
S 5 0005 0010 1000 0204 0000
E 3 0010 0005 3800
C 0 0
S 4 0005 0010 0000 0204
E 4 0010 0005 2000 0000
# Error responses and a write that has no effect
S 4 0005 0010 0000 0100
E 3 0010 0005 3000
S 4 0005 0010 0000 0205
E 3 0010 0005 3000
S 5 0005 0010 1000 0001 1234
E 3 0010 0005 3c00
S 5 0005 0010 1000 0200 abcd
E 3 0010 0005 3800
S 4 0005 0010 0000 0200
E 4 0010 0005 2000 0001
# Dropped packets, wrong destination and event type
S 4 0009 0010 0000 0000
S 4 0005 0010 0000 0001
E 4 0010 0005 2000 0001
S 4 0005 0010 4000 0000
S 4 0005 0010 0000 0201
E 4 0010 0005 2000 0002
# Same kind of traffic under random back-pressure
B 1
S 4 0005 0021 0000 0203
E 4 0021 0005 2000 000c
S 5 0005 0021 1000 0204 0003
E 3 0021 0005 3800
C 1 1
S 4 0005 0021 0000 0204
E 4 0021 0005 2000 0003
S 5 0005 0021 1000 0204 0000
E 3 0021 0005 3800
C 0 0
S 4 0005 0021 0000 0100
E 3 0021 0005 3000
B 0

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst
);

  // 20 ns clock period
  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset covers RST_CYCLES rising edges and drops on the falling edge after them
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/tb_osd_scm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_osd_scm
  import dii_pkg::*, scm_pkg::*;
();

  // Id the DUT answers to on the debug link
  localparam logic [15:0] DUT_ID = 16'h0005;
  // Clock cycles the watchdog grants for each stim line
  localparam int CYCLES_PER_LINE = 200;
  localparam string STIM_FILE = "bench/scm_stim.txt";

  logic                 clk;
  logic                 rst;
  logic [DII_WIDTH-1:0] debug_in_data = '0;
  logic                 debug_in_valid = 1'b0;
  logic                 debug_in_last = 1'b0;
  logic                 debug_in_ready;
  logic [DII_WIDTH-1:0] debug_out_data;
  logic                 debug_out_valid;
  logic                 debug_out_last;
  logic                 debug_out_ready = 1'b1;
  logic                 sys_rst;
  logic                 cpu_rst;

  // Seeded back-pressure source gives every run the same pattern
  integer seed = 32'hec11;
  logic   bp_on = 1'b0;

  // Every flit the DUT put out as {last, data} in link order
  logic [DII_WIDTH:0] rx_q[$];
  integer rx_rd = 0;
  integer wd_cycles = 0;
  integer fd;

  tb_clkgen u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  osd_scm_top u_dut (
    .clk             (clk),
    .rst             (rst),
    .id              (DUT_ID),
    .debug_in_data   (debug_in_data),
    .debug_in_valid  (debug_in_valid),
    .debug_in_last   (debug_in_last),
    .debug_in_ready  (debug_in_ready),
    .debug_out_data  (debug_out_data),
    .debug_out_valid (debug_out_valid),
    .debug_out_last  (debug_out_last),
    .debug_out_ready (debug_out_ready),
    .sys_rst         (sys_rst),
    .cpu_rst         (cpu_rst)
  );

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // One response flit against the expected word and end marker
  task automatic check_flit(input logic [DII_WIDTH-1:0] exp_data, input logic exp_last,
                            input logic [DII_WIDTH-1:0] got_data, input logic got_last);
    if (got_data !== exp_data) begin
      abort_run($sformatf("Mismatch at %0t: debug_out_data expected %h got %h",
                          $time, exp_data, got_data));
    end else if (got_last !== exp_last) begin
      abort_run($sformatf("Mismatch at %0t: debug_out_last expected %b got %b",
                          $time, exp_last, got_last));
    end
  endtask

  task automatic check_rst(input logic exp_sys, input logic exp_cpu);
    if (sys_rst !== exp_sys) begin
      abort_run($sformatf("Mismatch at %0t: sys_rst expected %b got %b",
                          $time, exp_sys, sys_rst));
    end else if (cpu_rst !== exp_cpu) begin
      abort_run($sformatf("Mismatch at %0t: cpu_rst expected %b got %b",
                          $time, exp_cpu, cpu_rst));
    end
  endtask

  // Input ready level against the one-packet-at-a-time rule
  task automatic check_ready(input logic exp_ready);
    if (debug_in_ready !== exp_ready) begin
      abort_run($sformatf("Mismatch at %0t: debug_in_ready expected %b got %b",
                          $time, exp_ready, debug_in_ready));
    end
  endtask

  //////////////////////////////
  // Link drivers
  //////////////////////////////

  // Offers one flit on a falling edge and holds it until taken
  task automatic send_flit(input logic [DII_WIDTH-1:0] data, input logic last);
    debug_in_data  = data;
    debug_in_last  = last;
    debug_in_valid = 1'b1;
    // Ready depends on the FSM state alone and is settled here
    while (!debug_in_ready) @(negedge clk);
    // The flit moved on the rising edge in between
    @(negedge clk);
  endtask

  // Ready changes on the falling edge and a flit offered with ready high
  // moves on the next rising edge, so it is recorded right here
  always @(negedge clk) begin : drive_out_ready
    logic [31:0] rnd;
    if (bp_on) begin
      rnd = $random(seed);
      debug_out_ready = rnd[0];
    end else begin
      debug_out_ready = 1'b1;
    end
    if (debug_out_valid && debug_out_ready) begin
      rx_q.push_back({debug_out_last, debug_out_data});
    end
  end

  //////////////////////////////
  // Stim file runner
  //////////////////////////////

  initial begin : run_stim
    string                cmd;
    string                line;
    integer               code;
    integer               n_lines;
    integer               n;
    integer               i;
    integer               v_sys;
    integer               v_cpu;
    logic [DII_WIDTH-1:0] word;
    logic [DII_WIDTH:0]   got;
    n_lines = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run({"Cannot open stim file ", STIM_FILE});
    end
    // First pass only sizes the watchdog
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code != 0) n_lines = n_lines + 1;
    end
    $fclose(fd);
    wd_cycles = CYCLES_PER_LINE * n_lines;
    fd = $fopen(STIM_FILE, "r");
    @(posedge clk);
    while (rst !== 1'b0) @(posedge clk);
    @(negedge clk);
    // All commands run on falling edges from here on
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        code = $fgets(line, fd);
      end else if (cmd == "S") begin
        code = $fscanf(fd, "%d", n);
        for (i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", word);
          send_flit(word, i == n - 1);
        end
        debug_in_valid = 1'b0;
        debug_in_last  = 1'b0;
        // The engine takes no new flit right after the last one of a request
        check_ready(1'b0);
      end else if (cmd == "E") begin
        code = $fscanf(fd, "%d", n);
        for (i = 0; i < n; i++) begin
          code = $fscanf(fd, "%h", word);
          while (rx_q.size() <= rx_rd) @(negedge clk);
          got = rx_q[rx_rd];
          rx_rd = rx_rd + 1;
          check_flit(word, i == n - 1, got[DII_WIDTH-1:0], got[DII_WIDTH]);
        end
      end else if (cmd == "C") begin
        code = $fscanf(fd, "%d %d", v_sys, v_cpu);
        @(negedge clk);
        check_rst(v_sys[0], v_cpu[0]);
      end else if (cmd == "B") begin
        code = $fscanf(fd, "%d", n);
        bp_on = (n != 0);
      end else begin
        abort_run({"Unknown command in stim file: ", cmd});
      end
    end
    $fclose(fd);
    // Give a stray response time to show up
    repeat (20) @(negedge clk);
    // An idle engine is ready for the next request
    check_ready(1'b1);
    if (rx_q.size() != rx_rd) begin
      abort_run($sformatf("DUT sent %0d response flits that no request asked for",
                          rx_q.size() - rx_rd));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    abort_run($sformatf("Timeout: response stalled, run not done after %0d cycles",
                        wd_cycles));
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/dii_pkg.sv
verilog/scm_pkg.sv
verilog/osd_regaccess.sv
verilog/osd_scm_regs.sv
verilog/osd_scm_top.sv
bench/tb_clkgen.sv
bench/tb_osd_scm.sv

// ==== verilog/dii_pkg.sv ====
`default_nettype none

package dii_pkg;

  //////////////////////////////
  // Link geometry
  //////////////////////////////

  // Every flit on the debug link is one 16-bit word
  localparam int DII_WIDTH = 16;

  // Word order inside a register access packet
  localparam logic [2:0] WORD_DEST  = 3'd0;
  localparam logic [2:0] WORD_SRC   = 3'd1;
  localparam logic [2:0] WORD_FLAGS = 3'd2;
  localparam logic [2:0] WORD_ADDR  = 3'd3;
  // Only write requests carry this word
  localparam logic [2:0] WORD_WDATA = 3'd4;

  //////////////////////////////
  // Flags word layout
  //////////////////////////////

  // Type sits in the top two bits, the subtype right below it
  localparam int TYPE_MSB    = 15;
  localparam int TYPE_LSB    = 14;
  localparam int SUBTYPE_MSB = 13;
  localparam int SUBTYPE_LSB = 10;

  // Packet class carried in the type field
  typedef enum logic [1:0] {
    TYPE_REG   = 2'b00,
    TYPE_EVENT = 2'b01,
    TYPE_PLAIN = 2'b10
  } dii_type_e;

  // Register access opcodes, requests have the top bit clear
  typedef enum logic [3:0] {
    REQ_READ_REG_16          = 4'b0000,
    REQ_WRITE_REG_16         = 4'b0100,
    RESP_READ_REG_SUCCESS_16 = 4'b1000,
    RESP_READ_REG_ERROR      = 4'b1100,
    RESP_WRITE_REG_SUCCESS   = 4'b1110,
    RESP_WRITE_REG_ERROR     = 4'b1111
  } dii_subtype_e;

endpackage

`default_nettype wire

// ==== verilog/osd_regaccess.sv ====
`timescale 1ns/1ps
`default_nettype none

module osd_regaccess
  import dii_pkg::*, scm_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [15:0]          id,
  input  logic [DII_WIDTH-1:0] debug_in_data,
  input  logic                 debug_in_valid,
  input  logic                 debug_in_last,
  output logic                 debug_in_ready,
  output logic [DII_WIDTH-1:0] debug_out_data,
  output logic                 debug_out_valid,
  output logic                 debug_out_last,
  input  logic                 debug_out_ready,
  output logic                 reg_request,
  output logic                 reg_write,
  output logic [15:0]          reg_addr,
  output logic [15:0]          reg_wdata,
  input  logic                 reg_ack,
  input  logic                 reg_err,
  input  logic [15:0]          reg_rdata
);

  typedef enum logic [3:0] {
    RX_HEADER, RX_ADDR, RX_DATA, RX_DROP, ACCESS,
    TX_DEST, TX_SRC, TX_FLAGS, TX_DATA
  } state_e;

  state_e state;

  // Position of the next input word inside the packet
  logic [2:0] word_cnt;

  // Set once the packet is known to need no answer
  logic drop_q;

  // Request fields, kept until the response has gone out
  logic                 write_q;
  logic [15:0]          src_q;
  logic [15:0]          addr_q;
  logic [15:0]          wdata_q;
  dii_subtype_e         resp_subtype_q;
  logic [15:0]          resp_data_q;

  logic                 in_fire;
  logic                 out_fire;
  logic                 flags_bad;
  logic                 flags_write;
  logic                 pkt_end;
  logic                 base_hit;
  logic [15:0]          base_rdata;
  logic                 access_ok;
  logic                 resp_has_data;
  logic [DII_WIDTH-1:0] resp_flags;

  assign in_fire  = debug_in_valid & debug_in_ready;
  assign out_fire = debug_out_valid & debug_out_ready;

  //////////////////////////////
  // Request decode
  //////////////////////////////

  // Only 16-bit register reads and writes are accepted
  assign flags_write = (debug_in_data[SUBTYPE_MSB:SUBTYPE_LSB] == REQ_WRITE_REG_16);
  assign flags_bad   = (debug_in_data[TYPE_MSB:TYPE_LSB] != TYPE_REG) |
                       ((debug_in_data[SUBTYPE_MSB:SUBTYPE_LSB] != REQ_READ_REG_16) &
                        !flags_write);

  // A read ends on the address word, a write on the data word
  assign pkt_end = (word_cnt == (write_q ? WORD_WDATA : WORD_ADDR));

  // The base registers never leave this block
  always_comb begin
    base_hit   = 1'b1;
    base_rdata = '0;
    case (addr_q)
      ADDR_MOD_VENDOR:  base_rdata = MOD_VENDOR;
      ADDR_MOD_TYPE:    base_rdata = MOD_TYPE;
      ADDR_MOD_VERSION: base_rdata = MOD_VERSION;
      default:          base_hit   = 1'b0;
    endcase
  end

  // Register block access is a single cycle in ACCESS
  assign reg_request = (state == ACCESS) & !drop_q & !base_hit;
  assign reg_write   = write_q;
  assign reg_addr    = addr_q;
  assign reg_wdata   = wdata_q;

  // Base registers are read only, so a write to them fails
  assign access_ok = base_hit ? !write_q : (reg_ack & !reg_err);

  //////////////////////////////
  // Packet state machine
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_HEADER;
      word_cnt <= '0;
      drop_q   <= 1'b0;
    end else begin
      case (state)
        RX_HEADER: begin
          if (in_fire) begin
            word_cnt <= word_cnt + 3'd1;
            case (word_cnt)
              WORD_DEST:  drop_q  <= (debug_in_data != id);
              WORD_SRC:   src_q   <= debug_in_data;
              WORD_FLAGS: begin
                drop_q  <= drop_q | flags_bad;
                write_q <= flags_write;
              end
              default: ;
            endcase
            // A packet too short to hold an address is thrown away
            if (debug_in_last) begin
              drop_q <= 1'b1;
              state  <= ACCESS;
            end else if (word_cnt == WORD_FLAGS) begin
              state <= (drop_q | flags_bad) ? RX_DROP : RX_ADDR;
            end
          end
        end
        RX_ADDR, RX_DATA: begin
          if (in_fire) begin
            word_cnt <= word_cnt + 3'd1;
            if (state == RX_ADDR) begin
              addr_q <= debug_in_data;
            end else begin
              wdata_q <= debug_in_data;
            end
            // Length must match the opcode or the packet is dropped
            if (debug_in_last) begin
              drop_q <= drop_q | !pkt_end;
              state  <= ACCESS;
            end else if (pkt_end) begin
              drop_q <= 1'b1;
              state  <= RX_DROP;
            end else begin
              state <= RX_DATA;
            end
          end
        end
        RX_DROP: begin
          // Swallow the rest of the packet
          if (in_fire && debug_in_last) begin
            state <= ACCESS;
          end
        end
        ACCESS: begin
          word_cnt <= '0;
          drop_q   <= 1'b0;
          if (drop_q) begin
            state <= RX_HEADER;
          end else begin
            resp_data_q <= base_hit ? base_rdata : reg_rdata;
            if (write_q) begin
              resp_subtype_q <= access_ok ? RESP_WRITE_REG_SUCCESS : RESP_WRITE_REG_ERROR;
            end else begin
              resp_subtype_q <= access_ok ? RESP_READ_REG_SUCCESS_16 : RESP_READ_REG_ERROR;
            end
            state <= TX_DEST;
          end
        end
        TX_DEST: if (out_fire) state <= TX_SRC;
        TX_SRC:  if (out_fire) state <= TX_FLAGS;
        TX_FLAGS: begin
          if (out_fire) begin
            state <= resp_has_data ? TX_DATA : RX_HEADER;
          end
        end
        TX_DATA: if (out_fire) state <= RX_HEADER;
        default: state <= RX_HEADER;
      endcase
    end
  end

  //////////////////////////////
  // Response output
  //////////////////////////////

  // Only a successful read carries a data flit
  assign resp_has_data = (resp_subtype_q == RESP_READ_REG_SUCCESS_16);

  always_comb begin
    resp_flags = '0;
    resp_flags[TYPE_MSB:TYPE_LSB]       = TYPE_REG;
    resp_flags[SUBTYPE_MSB:SUBTYPE_LSB] = resp_subtype_q;
  end

  assign debug_in_ready = (state == RX_HEADER) | (state == RX_ADDR) |
                          (state == RX_DATA) | (state == RX_DROP);

  always_comb begin
    debug_out_valid = 1'b1;
    debug_out_last  = 1'b0;
    debug_out_data  = '0;
    case (state)
      // The answer goes back to whoever asked
      TX_DEST:  debug_out_data = src_q;
      TX_SRC:   debug_out_data = id;
      TX_FLAGS: begin
        debug_out_data = resp_flags;
        debug_out_last = !resp_has_data;
      end
      TX_DATA: begin
        debug_out_data = resp_data_q;
        debug_out_last = 1'b1;
      end
      default:  debug_out_valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/osd_scm_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module osd_scm_regs
  import scm_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        reg_request,
  input  logic        reg_write,
  input  logic [15:0] reg_addr,
  input  logic [15:0] reg_wdata,
  output logic        reg_ack,
  output logic        reg_err,
  output logic [15:0] reg_rdata,
  output logic        sys_rst,
  output logic        cpu_rst
);

  // Bit 0 holds the system in reset, bit 1 the CPU
  logic [1:0] rst_vector;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Every request is answered in the same cycle
  assign reg_ack = reg_request;

  always_comb begin
    reg_rdata = '0;
    reg_err   = 1'b0;
    case (reg_addr)
      ADDR_SYS_VENDOR:  reg_rdata = SYSTEM_VENDOR_ID;
      ADDR_SYS_DEVICE:  reg_rdata = SYSTEM_DEVICE_ID;
      ADDR_NUM_MOD:     reg_rdata = NUM_MOD;
      ADDR_MAX_PKT_LEN: reg_rdata = MAX_PKT_LEN;
      ADDR_RST_VECTOR:  reg_rdata = {14'h0, rst_vector};
      // Unmapped addresses report an error back to the host
      default:          reg_err   = reg_request;
    endcase
  end

  //////////////////////////////
  // Reset vector
  //////////////////////////////

  // Identity registers ignore writes, only the vector stores data
  always_ff @(posedge clk) begin
    if (rst) begin
      rst_vector <= 2'b00;
    end else if (reg_request && reg_write && (reg_addr == ADDR_RST_VECTOR)) begin
      rst_vector <= reg_wdata[1:0];
    end
  end

  // The host may hold either domain in reset on top of the system reset
  assign sys_rst = rst_vector[RST_SYS_BIT] | rst;
  assign cpu_rst = rst_vector[RST_CPU_BIT] | rst;

endmodule

`default_nettype wire

// ==== verilog/osd_scm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module osd_scm_top
  import dii_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [15:0]          id,
  input  logic [DII_WIDTH-1:0] debug_in_data,
  input  logic                 debug_in_valid,
  input  logic                 debug_in_last,
  output logic                 debug_in_ready,
  output logic [DII_WIDTH-1:0] debug_out_data,
  output logic                 debug_out_valid,
  output logic                 debug_out_last,
  input  logic                 debug_out_ready,
  output logic                 sys_rst,
  output logic                 cpu_rst
);

  // Register access bus between the engine and the control registers
  logic        reg_request;
  logic        reg_write;
  logic [15:0] reg_addr;
  logic [15:0] reg_wdata;
  logic        reg_ack;
  logic        reg_err;
  logic [15:0] reg_rdata;

  // Packet side, turns link packets into register accesses
  osd_regaccess u_regaccess (
    .clk             (clk),
    .rst             (rst),
    .id              (id),
    .debug_in_data   (debug_in_data),
    .debug_in_valid  (debug_in_valid),
    .debug_in_last   (debug_in_last),
    .debug_in_ready  (debug_in_ready),
    .debug_out_data  (debug_out_data),
    .debug_out_valid (debug_out_valid),
    .debug_out_last  (debug_out_last),
    .debug_out_ready (debug_out_ready),
    .reg_request     (reg_request),
    .reg_write       (reg_write),
    .reg_addr        (reg_addr),
    .reg_wdata       (reg_wdata),
    .reg_ack         (reg_ack),
    .reg_err         (reg_err),
    .reg_rdata       (reg_rdata)
  );

  // Identity registers and the reset lines
  osd_scm_regs u_scm_regs (
    .clk         (clk),
    .rst         (rst),
    .reg_request (reg_request),
    .reg_write   (reg_write),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_ack     (reg_ack),
    .reg_err     (reg_err),
    .reg_rdata   (reg_rdata),
    .sys_rst     (sys_rst),
    .cpu_rst     (cpu_rst)
  );

endmodule

`default_nettype wire

// ==== verilog/scm_pkg.sv ====
`default_nettype none

package scm_pkg;

  //////////////////////////////
  // System identity
  //////////////////////////////

  // Values the host reads to learn what it is attached to
  localparam logic [15:0] SYSTEM_VENDOR_ID = 16'h0001;
  localparam logic [15:0] SYSTEM_DEVICE_ID = 16'h0002;
  localparam logic [15:0] NUM_MOD          = 16'h0001;
  localparam logic [15:0] MAX_PKT_LEN      = 16'd12;

  // Base identity of the control module itself
  localparam logic [15:0] MOD_VENDOR  = 16'h0001;
  localparam logic [15:0] MOD_TYPE    = 16'h0001;
  localparam logic [15:0] MOD_VERSION = 16'h0000;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Base registers, served inside the access engine
  localparam logic [15:0] ADDR_MOD_VENDOR  = 16'h0000;
  localparam logic [15:0] ADDR_MOD_TYPE    = 16'h0001;
  localparam logic [15:0] ADDR_MOD_VERSION = 16'h0002;

  // Control registers, served by the register block
  localparam logic [15:0] ADDR_SYS_VENDOR  = 16'h0200;
  localparam logic [15:0] ADDR_SYS_DEVICE  = 16'h0201;
  localparam logic [15:0] ADDR_NUM_MOD     = 16'h0202;
  localparam logic [15:0] ADDR_MAX_PKT_LEN = 16'h0203;
  localparam logic [15:0] ADDR_RST_VECTOR  = 16'h0204;

  // Bit positions inside the reset vector
  localparam int RST_SYS_BIT = 0;
  localparam int RST_CPU_BIT = 1;

endpackage

`default_nettype wire
